/* design/noc_pkg.sv */
`default_nettype none

package noc_pkg;

    // Tile geometry.
    localparam int num_links   = 4;
    localparam int num_sources = num_links + 1;  // Links plus the local port.
    localparam int flit_width  = 16;
    localparam int rx_depth    = 4;

    typedef logic [3:0] node_id_t;
    typedef logic [1:0] link_idx_t;
    typedef logic [7:0] payload_t;

    // Source number at the arbiter, the local port is the last one.
    typedef logic [$clog2(num_sources)-1:0] src_idx_t;

    // Local receive FIFO addressing.
    typedef logic [$clog2(rx_depth)-1:0] rx_ptr_t;
    typedef logic [$clog2(rx_depth):0]   rx_count_t;

    // Single-flit packet, dest in the top nibble.
    typedef struct packed {
        node_id_t dest;
        node_id_t src;
        payload_t payload;
    } flit_t;

endpackage

`default_nettype wire

/* design/serial_pkg.sv */
`default_nettype none

package serial_pkg;

    localparam int bit_cycles = 4;   // Clocks per serial bit.
    localparam int frame_bits = 19;  // Start, 16 data, parity, stop.

    typedef logic [$clog2(bit_cycles)-1:0] baud_cnt_t;
    typedef logic [$clog2(frame_bits)-1:0] bit_cnt_t;

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    typedef enum logic {
        tx_idle,
        tx_shift
    } tx_state_t;

endpackage

`default_nettype wire

/* design/link_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module link_unit
    import noc_pkg::*;
    import serial_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  serial_in,
    input  wire logic  take,
    input  wire logic  send,
    input  wire flit_t send_flit,
    output logic       serial_out,
    output logic       held_valid,
    output flit_t      held_flit,
    output logic       tx_busy,
    output logic       parity_error
);
    logic [1:0]            rx_sync;
    logic                  rx_bit;
    rx_state_t             rx_state;
    baud_cnt_t             rx_baud;
    bit_cnt_t              rx_count;
    logic [flit_width-1:0] rx_shift;
    logic                  rx_par;
    logic                  rx_mid;
    logic                  frame_ok;
    logic                  frame_bad;

    tx_state_t             tx_state;
    baud_cnt_t             tx_baud;
    bit_cnt_t              tx_count;
    logic [frame_bits-2:0] tx_frame;  // Bits still to go after the start bit.
    logic                  tx_bit_end;

    // Two-flop synchronizer on the line.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], serial_in};
        end
    end

    assign rx_bit = rx_sync[1];
    assign rx_mid = (rx_baud == baud_cnt_t'(bit_cycles - 1));

    // Even parity over data and parity bit, stop bit must be high.
    assign frame_ok  = (rx_state == rx_stop) && rx_mid && rx_bit && ~^{rx_shift, rx_par};
    assign frame_bad = (rx_state == rx_stop) && rx_mid && rx_bit && ^{rx_shift, rx_par};

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state     <= rx_idle;
            rx_baud      <= '0;
            rx_count     <= '0;
            held_valid   <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            if (take) begin
                held_valid <= 1'b0;
            end
            if (frame_ok) begin
                held_valid <= 1'b1;  // Overwrites a flit not yet taken.
            end
            if (frame_bad) begin
                parity_error <= 1'b1;
            end
            case (rx_state)
                rx_idle: begin
                    rx_baud <= '0;
                    if (!rx_bit) begin
                        rx_state <= rx_start;
                    end
                end
                rx_start: begin
                    rx_baud <= rx_baud + 1'b1;
                    // Middle of the start bit.
                    if (rx_baud == baud_cnt_t'(bit_cycles / 2 - 1)) begin
                        rx_baud  <= '0;
                        rx_count <= '0;
                        rx_state <= rx_bit ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    rx_baud <= rx_mid ? '0 : rx_baud + 1'b1;
                    if (rx_mid) begin
                        rx_count <= rx_count + 1'b1;
                        if (rx_count == bit_cnt_t'(flit_width - 1)) begin
                            rx_state <= rx_parity;
                        end
                    end
                end
                rx_parity: begin
                    rx_baud <= rx_mid ? '0 : rx_baud + 1'b1;
                    if (rx_mid) begin
                        rx_state <= rx_stop;
                    end
                end
                rx_stop: begin
                    rx_baud <= rx_mid ? '0 : rx_baud + 1'b1;
                    if (rx_mid) begin
                        rx_state <= rx_idle;
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

    // Receive data path, LSB arrives first.
    always_ff @(posedge clk) begin
        if (rx_state == rx_data && rx_mid) begin
            rx_shift <= {rx_bit, rx_shift[flit_width-1:1]};
        end
        if (rx_state == rx_parity && rx_mid) begin
            rx_par <= rx_bit;
        end
        if (frame_ok) begin
            held_flit <= flit_t'(rx_shift);
        end
    end

    assign tx_busy    = (tx_state == tx_shift);
    assign tx_bit_end = (tx_baud == baud_cnt_t'(bit_cycles - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state   <= tx_idle;
            tx_baud    <= '0;
            tx_count   <= '0;
            serial_out <= 1'b1;
        end else begin
            case (tx_state)
                tx_idle: begin
                    if (send) begin
                        tx_state   <= tx_shift;
                        tx_baud    <= '0;
                        tx_count   <= '0;
                        serial_out <= 1'b0;  // Start bit.
                    end
                end
                tx_shift: begin
                    tx_baud <= tx_bit_end ? '0 : tx_baud + 1'b1;
                    if (tx_bit_end) begin
                        tx_count   <= tx_count + 1'b1;
                        serial_out <= tx_frame[0];
                        if (tx_count == bit_cnt_t'(frame_bits - 1)) begin
                            tx_state   <= tx_idle;
                            serial_out <= 1'b1;
                        end
                    end
                end
                default: tx_state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_state == tx_idle && send) begin
            tx_frame <= {1'b1, ^send_flit, send_flit};
        end else if (tx_state == tx_shift && tx_bit_end) begin
            tx_frame <= {1'b1, tx_frame[frame_bits-2:1]};
        end
    end

endmodule

`default_nettype wire

/* design/ingress_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_arbiter
    import noc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [num_links:0]     held_valid,
    input  wire flit_t [num_links:0]    held_flit,
    input  wire logic                   ready,
    output logic [num_links:0]          take,
    output logic                        route_valid,
    output flit_t                       route_flit
);
    src_idx_t ptr;        // Highest priority source.
    src_idx_t grant_idx;
    logic     grant_found;

    // First valid source at or after the pointer.
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = ptr;
        for (int off = 0; off < num_sources; off++) begin
            idx = int'(ptr) + off;
            if (idx >= num_sources) begin
                idx = idx - num_sources;
            end
            if (!grant_found && held_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = src_idx_t'(idx);
            end
        end
    end

    always_comb begin
        take = '0;
        if (ready && grant_found) begin
            take[grant_idx] = 1'b1;
        end
    end

    assign route_valid = ready && grant_found;
    assign route_flit  = held_flit[grant_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (route_valid) begin
            // Skip past the winner.
            if (grant_idx == src_idx_t'(num_sources - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/egress_router.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_router
    import noc_pkg::*;
#(
    parameter node_id_t node_id = '0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 route_valid,
    input  wire flit_t                route_flit,
    input  wire logic [num_links-1:0] tx_busy,
    input  wire logic                 fifo_full,
    output logic                      ready,
    output logic [num_links-1:0]      send,
    output flit_t                     send_flit,
    output logic                      deliver,
    output flit_t                     deliver_flit
);
    logic      buf_valid;
    flit_t     buf_flit;
    logic      to_local;
    link_idx_t tgt_link;
    logic      released;

    assign ready    = !buf_valid;
    assign to_local = (buf_flit.dest == node_id);
    assign tgt_link = buf_flit.dest[$bits(link_idx_t)-1:0];  // Low bits pick the link.

    // Release as soon as the one target is free.
    always_comb begin
        send    = '0;
        deliver = 1'b0;
        if (buf_valid) begin
            if (to_local) begin
                deliver = !fifo_full;
            end else begin
                send[tgt_link] = !tx_busy[tgt_link];
            end
        end
    end

    assign released     = deliver || (|send);
    assign send_flit    = buf_flit;
    assign deliver_flit = buf_flit;

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (route_valid && ready) begin
            buf_valid <= 1'b1;
        end else if (released) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (route_valid && ready) begin
            buf_flit <= route_flit;
        end
    end

endmodule

`default_nettype wire

/* design/local_port.sv */
`timescale 1ns/1ps
`default_nettype none

module local_port
    import noc_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  inject_valid,
    input  wire flit_t inject_flit,
    input  wire logic  take,
    input  wire logic  deliver,
    input  wire flit_t deliver_flit,
    input  wire logic  recv_take,
    output logic       inject_busy,
    output logic       held_valid,
    output flit_t      held_flit,
    output logic       fifo_full,
    output logic       recv_valid,
    output flit_t      recv_flit
);
    logic      inj_valid;
    flit_t     inj_flit;
    flit_t     fifo_mem [rx_depth];
    rx_ptr_t   wr_ptr;
    rx_ptr_t   rd_ptr;
    rx_count_t fifo_count;
    logic      fifo_wr;
    logic      fifo_rd;

    // Injection side, one flit until the arbiter takes it.
    assign inject_busy = inj_valid;
    assign held_valid  = inj_valid;
    assign held_flit   = inj_flit;

    always_ff @(posedge clk) begin
        if (rst) begin
            inj_valid <= 1'b0;
        end else if (inj_valid) begin
            if (take) begin
                inj_valid <= 1'b0;
            end
        end else if (inject_valid) begin
            inj_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!inj_valid && inject_valid) begin
            inj_flit <= inject_flit;
        end
    end

    // Receive FIFO.
    assign fifo_full  = (fifo_count == rx_count_t'(rx_depth));
    assign recv_valid = (fifo_count != '0);
    assign recv_flit  = fifo_mem[rd_ptr];
    assign fifo_wr    = deliver && !fifo_full;
    assign fifo_rd    = recv_take && recv_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two.
            end
            if (fifo_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo_wr, fifo_rd})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_mem[wr_ptr] <= deliver_flit;
        end
    end

endmodule

`default_nettype wire

/* design/tile.sv */
`timescale 1ns/1ps
`default_nettype none

module tile
    import noc_pkg::*;
#(
    parameter node_id_t node_id = '0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [num_links-1:0] serial_in,
    output logic [num_links-1:0]      serial_out,
    input  wire logic                 inject_valid,
    input  wire flit_t                inject_flit,
    output logic                      inject_busy,
    output logic                      recv_valid,
    output flit_t                     recv_flit,
    input  wire logic                 recv_take,
    output logic [num_links-1:0]      parity_error
);
    // Drain side, the local port is source num_links.
    logic [num_links:0]     held_valid;
    flit_t [num_links:0]    held_flit;
    logic [num_links:0]     take;

    logic                   route_valid;
    flit_t                  route_flit;
    logic                   ready;

    // Feed side.
    logic [num_links-1:0]   send;
    flit_t                  send_flit;
    logic [num_links-1:0]   tx_busy;
    logic                   deliver;
    flit_t                  deliver_flit;
    logic                   fifo_full;

    local_port port (
        .clk(clk),
        .rst(rst),
        .inject_valid(inject_valid),
        .inject_flit(inject_flit),
        .take(take[num_links]),
        .deliver(deliver),
        .deliver_flit(deliver_flit),
        .recv_take(recv_take),
        .inject_busy(inject_busy),
        .held_valid(held_valid[num_links]),
        .held_flit(held_flit[num_links]),
        .fifo_full(fifo_full),
        .recv_valid(recv_valid),
        .recv_flit(recv_flit)
    );

    ingress_arbiter arbiter (
        .clk(clk),
        .rst(rst),
        .held_valid(held_valid),
        .held_flit(held_flit),
        .ready(ready),
        .take(take),
        .route_valid(route_valid),
        .route_flit(route_flit)
    );

    egress_router #(
        .node_id(node_id)
    ) router (
        .clk(clk),
        .rst(rst),
        .route_valid(route_valid),
        .route_flit(route_flit),
        .tx_busy(tx_busy),
        .fifo_full(fifo_full),
        .ready(ready),
        .send(send),
        .send_flit(send_flit),
        .deliver(deliver),
        .deliver_flit(deliver_flit)
    );

    genvar i;
    generate
        for (i = 0; i < num_links; i++) begin : g_link
            link_unit link (
                .clk(clk),
                .rst(rst),
                .serial_in(serial_in[i]),
                .take(take[i]),
                .send(send[i]),
                .send_flit(send_flit),
                .serial_out(serial_out[i]),
                .held_valid(held_valid[i]),
                .held_flit(held_flit[i]),
                .tx_busy(tx_busy[i]),
                .parity_error(parity_error[i])
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* test/tile_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_properties
    import noc_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 route_valid,
    input wire logic                 ready,
    input wire logic [num_links-1:0] send,
    input wire logic [num_links-1:0] serial_out,
    input wire logic [num_links-1:0] tx_busy,
    input wire logic [num_links:0]   held_valid,
    input wire logic [num_links:0]   take
);
    // A flit handed over fills the one-entry router.
    route_fills_router: assert property (@(posedge clk) disable iff (rst)
        route_valid |=> !ready)
        else $error("router still ready the clock after it accepted a flit");

    send_starts_frame: assert property (@(posedge clk) disable iff (rst)
        (send != '0) |=> ((tx_busy & $past(send)) == $past(send)))
        else $error("a link did not start its frame after send");

    idle_line_high: assert property (@(posedge clk) disable iff (rst)
        &(serial_out | tx_busy))
        else $error("serial_out low on a link with no frame in flight");

    // Taken source lets go of its flit.
    take_clears_source: assert property (@(posedge clk) disable iff (rst)
        (take != '0) |=> ((held_valid & $past(take)) == '0))
        else $error("a source still offered its flit after the arbiter took it");

endmodule

bind tile tile_properties props0 (
    .clk(clk),
    .rst(rst),
    .route_valid(route_valid),
    .ready(ready),
    .send(send),
    .serial_out(serial_out),
    .tx_busy(tx_busy),
    .held_valid(held_valid),
    .take(take)
);

`default_nettype wire

/* test/tile_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_checker
    import noc_pkg::*;
    import serial_pkg::*;
#(
    parameter node_id_t node_id = '0
) (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic [num_links-1:0] serial_out,
    input wire logic                 inject_busy,
    input wire logic                 recv_valid,
    input wire flit_t                recv_flit,
    input wire logic                 recv_take,
    input wire logic [num_links-1:0] parity_error
);
    // Expected flits per output. Output num_links is the local port.
    string exp_name [num_sources][$];
    flit_t exp_flit [num_sources][$];
    string bad_name [num_links][$];  // Corrupt frames per receiving link.
    int    outstanding = 0;
    int    n_pass = 0;
    int    n_fail = 0;

    logic [frame_bits-1:0] frame [num_links];
    int                    nbits [num_links];
    int                    phase [num_links];
    logic                  in_frame [num_links];
    logic [num_links-1:0]  perr_q;

    // Own id goes to the local port. Any other dest goes to link dest[1:0].
    function automatic int target_of(input flit_t f);
        if (f.dest == node_id) begin
            return num_links;
        end
        return int'(f.dest[1:0]);
    endfunction

    task automatic expect_row(input string name, input int src, input flit_t f,
                              input logic bad);
        if (bad) begin
            bad_name[src].push_back(name);
        end else begin
            exp_name[target_of(f)].push_back(name);
            exp_flit[target_of(f)].push_back(f);
        end
        outstanding++;
    endtask

    task automatic match_arrival(input int out, input flit_t got);
        string name;
        flit_t want;
        if (exp_flit[out].size() == 0) begin
            $display("unexpected flit %h arrived at output %0d", got, out);
            n_fail++;
        end else begin
            name = exp_name[out].pop_front();
            want = exp_flit[out].pop_front();
            outstanding--;
            if (got === want) begin
                $display("pass %s", name);
                n_pass++;
            end else begin
                $display("error %s: expected %h, actual %h", name, want, got);
                n_fail++;
            end
        end
    endtask

    task automatic check_frame(input int link, input logic [frame_bits-1:0] fr);
        if (fr[0] || !fr[frame_bits-1]) begin
            $display("frame on link %0d has a bad start or stop bit", link);
            n_fail++;
        end else if (^fr[frame_bits-2:1]) begin
            $display("frame on link %0d has odd parity", link);
            n_fail++;
        end else begin
            match_arrival(link, flit_t'(fr[flit_width:1]));
        end
    endtask

    // Back-pressure reaches the local port.
    task automatic confirm_stall();
        if (!(inject_busy && recv_valid)) begin
            $display("inject_busy fell while the receive FIFO was full");
            n_fail++;
        end
    endtask

    task automatic flush_pending();
        for (int o = 0; o < num_sources; o++) begin
            while (exp_name[o].size() != 0) begin
                $display("test %s never delivered its flit", exp_name[o].pop_front());
                n_fail++;
            end
            exp_flit[o].delete();
        end
        for (int l = 0; l < num_links; l++) begin
            while (bad_name[l].size() != 0) begin
                $display("test %s never raised parity_error", bad_name[l].pop_front());
                n_fail++;
            end
        end
    endtask

    always @(posedge clk) begin
        string name;
        if (rst) begin
            for (int l = 0; l < num_links; l++) begin
                in_frame[l] = 1'b0;
                phase[l]    = 0;
                nbits[l]    = 0;
            end
            perr_q = '0;
        end else begin
            // Frame decoder samples near mid-bit.
            for (int l = 0; l < num_links; l++) begin
                if (!in_frame[l] && !serial_out[l]) begin
                    in_frame[l] = 1'b1;
                    phase[l]    = 0;
                    nbits[l]    = 0;
                end else if (in_frame[l]) begin
                    phase[l]++;
                end
                if (in_frame[l] && phase[l] % bit_cycles == bit_cycles / 2) begin
                    frame[l] = {serial_out[l], frame[l][frame_bits-1:1]};
                    nbits[l]++;
                    if (nbits[l] == frame_bits) begin
                        in_frame[l] = 1'b0;
                        check_frame(l, frame[l]);
                    end
                end
            end
            if (recv_take && recv_valid) begin
                match_arrival(num_links, recv_flit);
            end
            for (int l = 0; l < num_links; l++) begin
                if (parity_error[l] && !perr_q[l]) begin
                    if (bad_name[l].size() != 0) begin
                        name = bad_name[l].pop_front();
                        $display("pass %s", name);
                        n_pass++;
                        outstanding--;
                    end else begin
                        $display("parity_error rose on link %0d with no corrupt frame sent", l);
                        n_fail++;
                    end
                end
            end
            perr_q = parity_error;
        end
    end

endmodule

`default_nettype wire

/* test/tile_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_tb
    import noc_pkg::*;
    import serial_pkg::*;
();
    localparam node_id_t tile_id   = 4'h5;
    localparam int       local_src = num_links;  // Source number of the local port.

    logic                 clk;
    logic                 rst;
    logic [num_links-1:0] serial_in;
    logic [num_links-1:0] serial_out;
    logic                 inject_valid;
    flit_t                inject_flit;
    logic                 inject_busy;
    logic                 recv_valid;
    flit_t                recv_flit;
    logic                 recv_take = 1'b0;
    logic [num_links-1:0] parity_error;

    // Stimulus table. Rows of one group start together.
    string row_name  [$];
    int    row_group [$];
    int    row_src   [$];
    flit_t row_flit  [$];
    logic  row_bad   [$];
    logic  row_hold  [$];  // Receive FIFO is not drained while the group runs.

    logic drain_en;
    int   cycles = 0;
    int   cycle_limit;

    tile #(
        .node_id(tile_id)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .serial_in(serial_in),
        .serial_out(serial_out),
        .inject_valid(inject_valid),
        .inject_flit(inject_flit),
        .inject_busy(inject_busy),
        .recv_valid(recv_valid),
        .recv_flit(recv_flit),
        .recv_take(recv_take),
        .parity_error(parity_error)
    );

    tile_checker #(
        .node_id(tile_id)
    ) chk0 (
        .clk(clk),
        .rst(rst),
        .serial_out(serial_out),
        .inject_busy(inject_busy),
        .recv_valid(recv_valid),
        .recv_flit(recv_flit),
        .recv_take(recv_take),
        .parity_error(parity_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        recv_take <= drain_en && recv_valid;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_row(input string name, input int group, input int src,
                           input node_id_t dest, input logic bad, input logic hold);
        flit_t f;
        f.dest    = dest;
        f.src     = node_id_t'(row_name.size());
        f.payload = payload_t'($urandom);
        row_name.push_back(name);
        row_group.push_back(group);
        row_src.push_back(src);
        row_flit.push_back(f);
        row_bad.push_back(bad);
        row_hold.push_back(hold);
    endtask

    // Frames on all links in mask run in step.
    task automatic send_frames(input logic [num_links-1:0] mask, input flit_t flits [num_links],
                               input logic [num_links-1:0] bad);
        logic [frame_bits-1:0] frame [num_links];
        for (int l = 0; l < num_links; l++) begin
            frame[l] = {1'b1, (^flits[l]) ^ bad[l], flits[l], 1'b0};
        end
        for (int b = 0; b < frame_bits; b++) begin
            @(posedge clk);
            for (int l = 0; l < num_links; l++) begin
                if (mask[l]) begin
                    serial_in[l] <= frame[l][0];
                end
                frame[l] = frame[l] >> 1;
            end
            repeat (bit_cycles - 1) @(posedge clk);
        end
    endtask

    task automatic inject_one(input flit_t f);
        @(posedge clk);
        while (inject_busy) begin
            @(posedge clk);
        end
        inject_valid <= 1'b1;
        inject_flit  <= f;
        @(posedge clk);
        inject_valid <= 1'b0;
    endtask

    initial begin
        flit_t                grp_flit [num_links];
        logic [num_links-1:0] grp_mask;
        logic [num_links-1:0] grp_bad;
        flit_t                local_q [$];
        int                   row;
        int                   first;

        void'($urandom(32'h29a3));
        serial_in    = '1;
        inject_valid = 1'b0;
        inject_flit  = '0;
        drain_en     = 1'b1;
        cycle_limit  = 0;
        rst          = 1'b1;

        add_row("local_to_link2", 0, local_src, 4'h2, 1'b0, 1'b0);
        add_row("link1_to_local", 1, 1, tile_id, 1'b0, 1'b0);
        add_row("link3_loopback", 2, 3, 4'h3, 1'b0, 1'b0);
        add_row("link0_to_link2", 3, 0, 4'h6, 1'b0, 1'b0);
        add_row("burst_link0", 4, 0, 4'h1, 1'b0, 1'b0);
        add_row("burst_link1", 4, 1, tile_id, 1'b0, 1'b0);
        add_row("burst_link2", 4, 2, 4'h0, 1'b0, 1'b0);
        add_row("burst_link3", 4, 3, 4'hb, 1'b0, 1'b0);
        add_row("parity_link2", 5, 2, 4'h1, 1'b1, 1'b0);
        for (int i = 0; i < rx_depth + 2; i++) begin
            add_row($sformatf("fifo_fill%0d", i), 6, local_src, tile_id, 1'b0, 1'b1);
        end
        cycle_limit = row_name.size() * 2 * frame_bits * bit_cycles + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        row = 0;
        while (row < row_name.size()) begin
            first    = row;
            grp_mask = '0;
            grp_bad  = '0;
            for (int l = 0; l < num_links; l++) begin
                grp_flit[l] = '0;
            end
            while (row < row_name.size() && row_group[row] == row_group[first]) begin
                chk0.expect_row(row_name[row], row_src[row], row_flit[row], row_bad[row]);
                if (row_src[row] == local_src) begin
                    local_q.push_back(row_flit[row]);
                end else begin
                    grp_mask[row_src[row]] = 1'b1;
                    grp_flit[row_src[row]] = row_flit[row];
                    grp_bad[row_src[row]]  = row_bad[row];
                end
                row++;
            end
            drain_en <= !row_hold[first];
            if (grp_mask != '0) begin
                send_frames(grp_mask, grp_flit, grp_bad);
            end
            while (local_q.size() != 0) begin
                inject_one(local_q.pop_front());
            end
            if (row_hold[first]) begin
                // Last flit stays stuck behind the full FIFO.
                repeat (5 * bit_cycles) @(posedge clk);
                chk0.confirm_stall();
                drain_en <= 1'b1;
            end
            while (chk0.outstanding != 0) begin
                @(posedge clk);
            end
        end

        repeat (2 * frame_bits * bit_cycles) @(posedge clk);  // Catch stray frames.
        chk0.flush_pending();
        $display("tests passed: %0d, failed: %0d", chk0.n_pass, chk0.n_fail);
        if (chk0.n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/noc_pkg.sv
design/serial_pkg.sv
design/link_unit.sv
design/ingress_arbiter.sv
design/egress_router.sv
design/local_port.sv
design/tile.sv
test/tile_properties.sv
test/tile_checker.sv
test/tile_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tile_tb -f sim.f --Mdir obj_dir -o tile_sim
./obj_dir/tile_sim 2>&1 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
